/* bench/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    localparam inst_t mem_key    = 32'h5a3c_96e1;
    localparam int    wait_limit = 200;
    localparam int    num_rows   = 7;

    // packets to consume, redirect target, deq_ready percentage
    typedef struct packed {
        logic [7:0] count;
        addr_t      target;
        logic [7:0] ready_pct;
    } stim_row_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       redirect;
    addr_t      redirect_pc;
    addr_t      imem_addr;
    logic [3:0] imem_rmask;
    inst_t      imem_rdata;
    logic       imem_resp;
    logic       deq_valid;
    logic       deq_ready;
    fetch_pkt_t deq_pkt;

    stim_row_t  stim_table [num_rows];
    addr_t      exp_pc;
    int         addr_errors;
    int         inst_errors;
    int         flag_errors;
    int         timeout_errors;
    logic       timed_out;

    always #5 clk = ~clk;

    fetch_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_rmask  (imem_rmask),
        .imem_rdata  (imem_rdata),
        .imem_resp   (imem_resp),
        .deq_valid   (deq_valid),
        .deq_ready   (deq_ready),
        .deq_pkt     (deq_pkt)
    );

    imem_model imem_i (
        .clk   (clk),
        .rst   (rst),
        .key   (mem_key),
        .addr  (imem_addr),
        .rmask (imem_rmask),
        .rdata (imem_rdata),
        .resp  (imem_resp)
    );

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, exp);
            addr_errors++;
        end
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, exp);
            inst_errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %b, expected %b", $time, what, got, exp);
            flag_errors++;
        end
    endtask

    task automatic load_table();
        // first row follows the reset stream
        stim_table[0] = '{8'd10, 32'h0000_2000, 8'd100};
        // slow decoder, queue fills and fetch stalls
        stim_table[1] = '{8'd12, 32'h0000_3000, 8'd20};
        // short rows put redirects close together
        stim_table[2] = '{8'd1, 32'h0000_4000, 8'd70};
        stim_table[3] = '{8'd0, 32'h0000_5000, 8'd100};
        stim_table[4] = '{8'd9, 32'h0000_6004, 8'd50};
        stim_table[5] = '{8'd2, 32'h0000_7000, 8'd90};
        stim_table[6] = '{8'd14, 32'h0000_8000, 8'd40};
    endtask

    // transfers are sampled at the edge, inputs move 1 ns later
    task automatic consume_packets(input int count, input int ready_pct);
        int got;
        int idle;
        got = 0;
        idle = 0;
        while (got < count) begin
            @(posedge clk);
            // a read strobe covers all four bytes or none
            check_flag((imem_rmask == 4'h0) || (imem_rmask == 4'hf), 1'b1,
                       "imem_rmask all ones or zero");
            if (deq_valid && deq_ready) begin
                check_addr(deq_pkt.pc, exp_pc, "dequeued pc");
                check_inst(deq_pkt.inst, exp_pc ^ mem_key, "dequeued inst");
                exp_pc = exp_pc + pc_step;
                got = got + 1;
                idle = 0;
            end else begin
                idle = idle + 1;
                if (idle >= wait_limit) begin
                    $display("timeout: no packet reached the decoder for %0d cycles at %0t",
                             wait_limit, $time);
                    timeout_errors++;
                    timed_out = 1'b1;
                    return;
                end
            end
            #1;
            deq_ready = (int'($urandom % 100) < ready_pct);
        end
    endtask

    task automatic pulse_redirect(input addr_t target);
        redirect    = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        check_flag(deq_valid, 1'b0, "deq_valid in redirect cycle");
        // the target is read from memory in the redirect cycle itself
        check_flag(&imem_rmask, 1'b1, "imem_rmask in redirect cycle");
        check_addr(imem_addr, target, "imem_addr in redirect cycle");
        #1;
        redirect = 1'b0;
        // old path is gone, stream restarts at the target
        exp_pc = target;
    endtask

    initial begin
        int total;
        void'($urandom(32'h36f8));
        rst            = 1'b1;
        redirect       = 1'b0;
        redirect_pc    = '0;
        deq_ready      = 1'b0;
        exp_pc         = reset_vector;
        addr_errors    = 0;
        inst_errors    = 0;
        flag_errors    = 0;
        timeout_errors = 0;
        timed_out      = 1'b0;
        load_table();

        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            // state is defined once the first reset edge has passed
            if (i > 0) begin
                check_flag(deq_valid, 1'b0, "deq_valid in reset");
                check_flag(|imem_rmask, 1'b0, "imem_rmask in reset");
            end
        end
        #1;
        rst       = 1'b0;
        deq_ready = 1'b1;
        @(posedge clk);
        check_flag(deq_valid, 1'b0, "deq_valid after reset");
        check_flag(|imem_rmask, 1'b0, "imem_rmask after reset");
        #1;

        for (int i = 0; i < num_rows; i++) begin
            if (!timed_out) begin
                consume_packets(int'(stim_table[i].count), int'(stim_table[i].ready_pct));
            end
            if (!timed_out) begin
                pulse_redirect(stim_table[i].target);
            end
        end

        total = addr_errors + inst_errors + flag_errors + timeout_errors;
        $display("errors: addr %0d, inst %0d, flag %0d, timeout %0d",
                 addr_errors, inst_errors, flag_errors, timeout_errors);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* bench/imem_model.sv */
`timescale 1ns/1ps

module imem_model import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // data returned is the address xor this key
    input  inst_t      key,

    input  addr_t      addr,
    input  logic [3:0] rmask,
    output inst_t      rdata,
    output logic       resp
);

    // reads in flight, oldest first
    addr_t       addr_q [$];
    int unsigned due_q [$];

    // index of the cycle that ends at the current edge
    int unsigned cyc = 0;
    int unsigned last_due = 0;

    initial begin
        resp  = 1'b0;
        rdata = '0;
    end

    always @(posedge clk) begin
        int unsigned lat;
        int unsigned due;
        if (rst) begin
            addr_q.delete();
            due_q.delete();
            last_due = cyc;
            resp  <= 1'b0;
            rdata <= '0;
        end else begin
            if (rmask != '0) begin
                lat = 1 + ($urandom % 4);
                due = cyc + lat;
                // answers stay in order, one per cycle
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                addr_q.push_back(addr);
                due_q.push_back(due);
                last_due = due;
            end
            // response for the cycle that starts now
            if (due_q.size() != 0 && due_q[0] <= cyc + 1) begin
                resp  <= 1'b1;
                rdata <= addr_q[0] ^ key;
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                resp <= 1'b0;
            end
        end
        cyc = cyc + 1;
    end

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

    // byte address of an instruction
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // pc and word travel together from fetch to decode
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_pkt_t;

    // first fetch address after reset
    localparam addr_t reset_vector = 32'h0000_1000;

    // sequential fetch increment
    localparam addr_t pc_step = 32'd4;

    // killed reads still owed by memory, up to 3
    typedef logic [1:0] stale_cnt_t;

    // instruction queue sizing
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = $clog2(queue_depth);

    // slot index into the queue
    typedef logic [queue_ptr_w-1:0] qptr_t;

    // occupancy, one extra bit so that full is representable
    typedef logic [queue_ptr_w:0] qcnt_t;

    // last valid slot index, used for pointer wrap
    localparam qptr_t queue_last = qptr_t'(queue_depth - 1);

    // occupancy at which the queue refuses new packets
    localparam qcnt_t queue_full = qcnt_t'(queue_depth);

endpackage

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       redirect,
    input  addr_t      redirect_pc,

    // instruction memory
    output addr_t      imem_addr,
    output logic [3:0] imem_rmask,
    input  inst_t      imem_rdata,
    input  logic       imem_resp,

    // decoder side
    output logic       deq_valid,
    input  logic       deq_ready,
    output fetch_pkt_t deq_pkt
);

    logic       req_valid;
    logic       req_ready;
    addr_t      req_pc;

    logic       pkt_valid;
    logic       pkt_ready;
    fetch_pkt_t pkt;

    pc_gen pc_gen_i (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_pc      (req_pc)
    );

    if1_stage if1_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (redirect),
        .prv_valid  (req_valid),
        .prv_ready  (req_ready),
        .pc_next    (req_pc),
        .nxt_valid  (pkt_valid),
        .nxt_ready  (pkt_ready),
        .nxt_pkt    (pkt),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp)
    );

    inst_queue queue_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (redirect),
        .enq_valid (pkt_valid),
        .enq_ready (pkt_ready),
        .enq_pkt   (pkt),
        .deq_valid (deq_valid),
        .deq_ready (deq_ready),
        .deq_pkt   (deq_pkt)
    );

endmodule

/* hw/if1_stage.sv */
`timescale 1ns/1ps

module if1_stage import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       flush,

    // previous stage handshake
    input  logic       prv_valid,
    output logic       prv_ready,
    input  addr_t      pc_next,

    // next stage handshake
    output logic       nxt_valid,
    input  logic       nxt_ready,
    output fetch_pkt_t nxt_pkt,

    // instruction memory port
    output addr_t      imem_addr,
    output logic [3:0] imem_rmask,
    input  inst_t      imem_rdata,
    input  logic       imem_resp
);

    logic       slot_valid;
    logic       pending;
    addr_t      pc_q;
    inst_t      inst_q;
    stale_cnt_t stale_cnt;

    logic       accept;
    logic       resp_live;
    logic       resp_stale;
    logic       waiting;
    logic       stale_inc;

    // free when empty, draining this cycle, or on redirect
    assign prv_ready = ~slot_valid || (nxt_valid && nxt_ready) || flush;
    assign accept    = prv_valid && prv_ready;

    // responses go to killed reads first, in order
    assign resp_stale = imem_resp && (stale_cnt != '0);
    assign resp_live  = imem_resp && (stale_cnt == '0);

    // a pending read that is not answered now becomes stale on flush
    assign stale_inc = flush && pending && ~resp_live;

    assign imem_addr  = pc_next;
    assign imem_rmask = {4{accept}};

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (resp_live || flush) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= 1'b0;
        end else if (prv_ready) begin
            slot_valid <= prv_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stale_cnt <= '0;
        end else begin
            case ({stale_inc, resp_stale})
                2'b10:   stale_cnt <= stale_cnt + 2'd1;
                2'b01:   stale_cnt <= stale_cnt - 2'd1;
                default: stale_cnt <= stale_cnt;
            endcase
        end
    end

    // keep the word once it has arrived
    always_ff @(posedge clk) begin
        if (resp_live) begin
            inst_q <= imem_rdata;
        end
    end

    assign waiting = pending && ~resp_live;

    // held word is dropped on flush
    assign nxt_valid    = slot_valid && ~waiting && ~flush;
    assign nxt_pkt.pc   = pc_q;
    assign nxt_pkt.inst = resp_live ? imem_rdata : inst_q;

endmodule

/* hw/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       flush,

    // from the fetch stage
    input  logic       enq_valid,
    output logic       enq_ready,
    input  fetch_pkt_t enq_pkt,

    // toward the decoder
    output logic       deq_valid,
    input  logic       deq_ready,
    output fetch_pkt_t deq_pkt
);

    fetch_pkt_t mem [queue_depth];
    qptr_t      wr_ptr;
    qptr_t      rd_ptr;
    qcnt_t      count;

    logic       do_enq;
    logic       do_deq;

    function automatic qptr_t next_ptr(input qptr_t ptr);
        if (ptr == queue_last) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign enq_ready = (count != queue_full);
    // nothing leaves in the flush cycle
    assign deq_valid = (count != '0) && ~flush;
    assign deq_pkt   = mem[rd_ptr];

    assign do_enq = enq_valid && enq_ready && ~flush;
    assign do_deq = deq_valid && deq_ready;

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_deq) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous enq and deq leave the count alone
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  redirect,
    input  addr_t redirect_pc,

    // request toward the fetch stage
    output logic  req_valid,
    input  logic  req_ready,
    output addr_t req_pc
);

    // next sequential fetch address
    addr_t pc_q;
    // low in reset, high from the first cycle after it
    logic  running;
    logic  accept;
    addr_t seq_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // redirect target goes out in the same cycle
    assign req_pc    = redirect ? redirect_pc : pc_q;
    assign req_valid = running || redirect;

    assign accept = req_valid && req_ready;
    assign seq_pc = req_pc + pc_step;

    // an accepted redirect continues from target + step
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= reset_vector;
        end else if (accept) begin
            pc_q <= seq_pc;
        end else if (redirect) begin
            // not taken this cycle, so retry the target next cycle
            pc_q <= redirect_pc;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module fetch_tb \
    -Mdir obj_dir \
    -f tb.f

./obj_dir/Vfetch_tb | tee sim.log

if grep -qx "Regression passed" sim.log; then
    echo "simulation ok"
    exit 0
fi

echo "simulation not ok"
exit 1

/* tb.f */
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/if1_stage.sv
hw/inst_queue.sv
hw/fetch_top.sv
bench/imem_model.sv
bench/fetch_tb.sv
